/* source/conv_pkg.sv */
package conv_pkg;

  // kernel geometry
  parameter int KSIZE    = 5;               // kernel edge, one row stream per kernel row
  parameter int NUM_TAPS = KSIZE * KSIZE;   // one mac tap per coefficient

  // datapath widths
  parameter int PIX_W   = 8;                // unsigned grey level
  parameter int COEFF_W = 18;               // signed, 16 fraction bits
  parameter int ACC_W   = 48;               // cascade sum, wide enough for 25 products

  // output pixel is sum[OUT_LSB +: PIX_W], truncated, no rounding
  parameter int OUT_LSB = 16;

  // register bus widths
  parameter int APB_AW = 8;                 // 64 words of address space
  parameter int APB_DW = 32;

  // scalar types
  typedef logic [PIX_W-1:0]          pixel_t;   // unsigned pixel
  typedef logic signed [COEFF_W-1:0] coeff_t;   // filter weight, 2.16 fixed point
  typedef logic signed [ACC_W-1:0]   acc_t;     // cascade sum between taps

  // apb request, driven by the bus master
  typedef struct packed {
    logic              psel;      // slave selected, setup and access phase
    logic              penable;   // high in the access phase only
    logic              pwrite;    // 1 write, 0 read
    logic [APB_AW-1:0] paddr;     // byte address, word aligned
    logic [APB_DW-1:0] pwdata;    // write data, low COEFF_W bits used
  } apb_req_t;

  // apb response, driven by the coefficient bank
  typedef struct packed {
    logic [APB_DW-1:0] prdata;    // read data, sign extended coefficient
    logic              pready;    // no wait states
    logic              pslverr;   // word index out of range
  } apb_rsp_t;

endpackage

/* source/coeff_regs.sv */
`timescale 1ns/1ps

module coeff_regs #(
  parameter int KSIZE = conv_pkg::KSIZE       // register count is KSIZE squared
) (
  input  logic                                clk,
  input  logic                                rst,
  input  conv_pkg::apb_req_t                  apb_req,
  output conv_pkg::apb_rsp_t                  apb_rsp,
  output conv_pkg::coeff_t [KSIZE*KSIZE-1:0]  coeff     // element i goes to tap i
);

  import conv_pkg::*;

  localparam int NUM_REGS = KSIZE * KSIZE;
  localparam int IDX_W    = APB_AW - 2;        // byte address bits 1:0 dropped
  localparam int EXT_W    = APB_DW - COEFF_W;  // sign bits added on readback

  logic [IDX_W-1:0] word_idx;   // register number from paddr
  logic             access;     // access phase of any transfer
  logic             addr_ok;    // word index inside the bank
  logic             wr_en;      // valid write in the access phase
  coeff_t           rd_coeff;   // addressed coefficient, 0 when out of range

  // address decode
  assign word_idx = apb_req.paddr[APB_AW-1:2];
  assign access   = apb_req.psel & apb_req.penable;
  assign addr_ok  = (word_idx < NUM_REGS);
  assign wr_en    = access & apb_req.pwrite & addr_ok;

  // readback mux
  always_comb begin
    if (addr_ok) begin
      rd_coeff = coeff[word_idx];   // index checked above
    end else begin
      rd_coeff = '0;                // no register behind this word
    end
  end

  // response, purely combinational in the access phase
  always_comb begin
    apb_rsp.pready  = access;                    // single cycle access
    apb_rsp.pslverr = access & ~addr_ok;         // flag word 25 and above
    if (access && !apb_req.pwrite) begin
      apb_rsp.prdata = {{EXT_W{rd_coeff[COEFF_W-1]}}, rd_coeff};  // sign extend
    end else begin
      apb_rsp.prdata = '0;                       // quiet bus outside reads
    end
  end

  // coefficient storage
  // a write lands on the edge that closes the access phase
  always_ff @(posedge clk) begin
    if (rst) begin
      coeff <= '0;                               // all taps start at zero weight
    end else if (wr_en) begin
      coeff[word_idx] <= apb_req.pwdata[COEFF_W-1:0];  // upper data bits ignored
    end
  end

endmodule

/* source/row_skew.sv */
`timescale 1ns/1ps

module row_skew #(
  parameter int KSIZE = conv_pkg::KSIZE       // rows, also the delay step per row
) (
  input  logic                              clk,
  input  logic                              rst,
  input  conv_pkg::pixel_t [KSIZE-1:0]      pix_in,    // row 0 is element 0
  output conv_pkg::pixel_t [KSIZE-1:0]      pix_skew   // row r delayed by KSIZE*r
);

  import conv_pkg::*;

  // row 0 needs no alignment
  assign pix_skew[0] = pix_in[0];

  // rows 1 and up, one shift register each
  // the tap cascade adds one cycle per tap, so a row further down the
  // kernel has to wait one full kernel width longer per row index
  for (genvar r = 1; r < KSIZE; r++) begin : gen_row
    localparam int DEPTH = KSIZE * r;           // 5, 10, 15, 20 for a 5x5 kernel

    pixel_t [DEPTH-1:0] sr;                     // stage 0 takes the new pixel

    always_ff @(posedge clk) begin
      if (rst) begin
        sr <= '0;                               // history starts black
      end else begin
        sr <= {sr[DEPTH-2:0], pix_in[r]};       // shift towards the top stage
      end
    end

    assign pix_skew[r] = sr[DEPTH-1];           // oldest stage feeds the taps
  end

endmodule

/* source/mac_tap.sv */
`timescale 1ns/1ps

module mac_tap #(
  parameter bit FIRST_TAP = 1'b0       // head of the cascade, pcin ignored
) (
  input  logic               clk,
  input  logic               rst,
  input  conv_pkg::pixel_t   pix,      // skewed pixel for this kernel row
  input  conv_pkg::coeff_t   coeff,    // weight of this tap
  input  conv_pkg::acc_t     pcin,     // sum from the previous tap
  output conv_pkg::acc_t     pcout     // sum towards the next tap
);

  import conv_pkg::*;

  localparam int PROD_W = PIX_W + 1 + COEFF_W;   // signed pixel times signed weight

  logic signed [PIX_W:0]    a_q;       // input stage, pixel with a zero sign bit
  coeff_t                   b_q;       // input stage, coefficient
  logic signed [PROD_W-1:0] m_q;       // product stage
  acc_t                     m_ext;     // product widened to the cascade width
  acc_t                     p_next;    // next cascade sum

  // signed assignment, so the product is sign extended
  assign m_ext = m_q;

  // cascade adder
  // the head tap starts a fresh sum for every output pixel
  always_comb begin
    if (FIRST_TAP) begin
      p_next = m_ext;
    end else begin
      p_next = pcin + m_ext;           // wraps silently, the sum never gets that big
    end
  end

  // three register stages, like a dsp slice with areg, mreg and preg set
  always_ff @(posedge clk) begin
    if (rst) begin
      a_q   <= '0;
      b_q   <= '0;
      m_q   <= '0;
      pcout <= '0;
    end else begin
      a_q   <= {1'b0, pix};            // pixels are unsigned
      b_q   <= coeff;
      m_q   <= a_q * b_q;              // both operands signed
      pcout <= p_next;                 // pcin is one cycle older than m_q
    end
  end

endmodule

/* source/conv5x5_top.sv */
`timescale 1ns/1ps

module conv5x5_top #(
  parameter int KSIZE = conv_pkg::KSIZE       // kernel edge, passed to every block
) (
  input  logic                              clk,
  input  logic                              rst,
  input  conv_pkg::apb_req_t                apb_req,   // coefficient programming
  output conv_pkg::apb_rsp_t                apb_rsp,
  input  conv_pkg::pixel_t [KSIZE-1:0]      pix_in,    // one pixel per row per cycle
  output conv_pkg::pixel_t                  pix_out    // filtered pixel, every cycle
);

  import conv_pkg::*;

  localparam int TAPS = KSIZE * KSIZE;

  coeff_t [TAPS-1:0]  coeff;       // weights from the register bank
  pixel_t [KSIZE-1:0] pix_skew;    // rows aligned to the cascade delay
  acc_t   [TAPS:0]    casc;        // casc[i] enters tap i, casc[TAPS] is the filter sum

  // register bank
  coeff_regs #(
    .KSIZE   (KSIZE)
  ) u_coeff_regs (
    .clk     (clk),
    .rst     (rst),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .coeff   (coeff)
  );

  // row alignment
  row_skew #(
    .KSIZE    (KSIZE)
  ) u_row_skew (
    .clk      (clk),
    .rst      (rst),
    .pix_in   (pix_in),
    .pix_skew (pix_skew)
  );

  // the head tap does not read its cascade input
  assign casc[0] = '0;

  // systolic chain, tap KSIZE*r+k weights row r, column k
  // column k reaches the end of the chain k cycles later than column 0,
  // which together with the row skew lines up a full kernel window
  for (genvar i = 0; i < TAPS; i++) begin : gen_tap
    mac_tap #(
      .FIRST_TAP (i == 0)
    ) u_mac_tap (
      .clk   (clk),
      .rst   (rst),
      .pix   (pix_skew[i / KSIZE]),   // row of this tap
      .coeff (coeff[i]),
      .pcin  (casc[i]),
      .pcout (casc[i+1])
    );
  end

  // drop the 16 fraction bits, keep 8 integer bits, wrap on overflow
  assign pix_out = casc[TAPS][OUT_LSB +: PIX_W];

endmodule

/* tests/apb_master_bfm.sv */
`timescale 1ns/1ps

module apb_master_bfm (
  input  logic               clk,
  output conv_pkg::apb_req_t apb_req,   // towards the coefficient bank
  input  conv_pkg::apb_rsp_t apb_rsp    // sampled at the rising edge
);

  import conv_pkg::*;

  int err_count = 0;                    // handshake errors seen on the bus

  initial apb_req = '0;                 // bus idle from time zero

  // one response flag against its expected level
  task automatic compare_flag(input string name, input string phase,
                              input logic [APB_AW-1:0] addr,
                              input logic exp, input logic act);
    if (act !== exp) begin
      err_count++;
      $display("Fail %s (%s, addr %h): expected %h, got %h", name, phase, addr, exp, act);
    end
  endtask

  // setup phase, access phase, then back to idle
  task automatic transfer(input logic wr, input logic [APB_AW-1:0] addr,
                          input logic [APB_DW-1:0] wdata, input logic exp_err,
                          output logic [APB_DW-1:0] rdata);
    @(negedge clk);
    apb_req.psel    = 1'b1;             // setup
    apb_req.penable = 1'b0;
    apb_req.pwrite  = wr;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(posedge clk);
    compare_flag("pready", "setup", addr, 1'b0, apb_rsp.pready);    // low outside access
    compare_flag("pslverr", "setup", addr, 1'b0, apb_rsp.pslverr);
    @(negedge clk);
    apb_req.penable = 1'b1;             // access
    @(posedge clk);
    compare_flag("pready", "access", addr, 1'b1, apb_rsp.pready);   // no wait states
    compare_flag("pslverr", "access", addr, exp_err, apb_rsp.pslverr);
    rdata = apb_rsp.prdata;             // taken at the closing edge
    @(negedge clk);
    apb_req = '0;                       // idle
  endtask

  task automatic write_word(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data,
                            input logic exp_err);
    logic [APB_DW-1:0] rsp_data;        // ignored on writes
    transfer(1'b1, addr, data, exp_err, rsp_data);
  endtask

  task automatic read_word(input logic [APB_AW-1:0] addr, output logic [APB_DW-1:0] data,
                           input logic exp_err);
    transfer(1'b0, addr, '0, exp_err, data);
  endtask

endmodule

/* tests/conv5x5_tb.sv */
`timescale 1ns/1ps

module conv5x5_tb;

  import conv_pkg::*;

  localparam int NUM_ENTRIES    = 4;    // identity, box blur, sharpen, random
  localparam int IDENTITY_ENTRY = 0;
  localparam int STREAM_LEN     = 60;   // random columns per kernel
  localparam int FLUSH_LEN      = 30;   // zero columns after the stream
  localparam int HIST_LEN       = 27;   // oldest column in the window is 26 edges back
  localparam int SETTLE         = 27;   // first fully checked cycle of a stream
  localparam int CLK_NS         = 20;
  localparam int CENTER         = NUM_TAPS / 2;   // tap 12, row 2 column 2
  localparam longint WATCHDOG_NS =
    (NUM_ENTRIES * (NUM_TAPS * 4 + STREAM_LEN + FLUSH_LEN) + 40) * CLK_NS * 2;

  logic               clk;
  logic               rst;
  apb_req_t           apb_req;
  apb_rsp_t           apb_rsp;
  pixel_t [KSIZE-1:0] pix_in;           // row 0 is element 0
  pixel_t             pix_out;

  integer seed = 28191;
  int     pix_errs = 0;                 // wrong output pixels
  int     rd_errs  = 0;                 // wrong readback words

  logic [APB_DW-1:0]  kernel_tab [0:NUM_ENTRIES-1][0:NUM_TAPS-1];  // raw write words
  logic [APB_DW-1:0]  exp_coeff [0:NUM_TAPS-1];    // expected bank contents
  pixel_t [KSIZE-1:0] col_hist [0:HIST_LEN-1];     // [0] is the newest captured column

  conv5x5_top #(
    .KSIZE   (KSIZE)
  ) dut0 (
    .clk     (clk),
    .rst     (rst),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .pix_in  (pix_in),
    .pix_out (pix_out)
  );

  apb_master_bfm bfm0 (
    .clk     (clk),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  // low 18 bits of a write word, read back as a 32 bit signed value
  function automatic logic [APB_DW-1:0] sign_extend_coeff(input logic [APB_DW-1:0] raw);
    return {{(APB_DW - COEFF_W){raw[COEFF_W-1]}}, raw[COEFF_W-1:0]};
  endfunction

  // window sum c[5r+k] * x_r[m-26+k], bits 23..16
  function automatic pixel_t ref_pixel();
    longint sum;
    sum = 0;
    for (int r = 0; r < KSIZE; r++) begin
      for (int k = 0; k < KSIZE; k++) begin
        sum += longint'(signed'(exp_coeff[r * KSIZE + k])) *
               longint'(col_hist[HIST_LEN - 1 - k][r]);   // pixel zero extended
      end
    end
    return sum[OUT_LSB +: PIX_W];       // truncation, wraps like the filter
  endfunction

  task automatic build_table();
    for (int i = 0; i < NUM_TAPS; i++) begin
      kernel_tab[0][i] = (i == CENTER) ? 32'd65536 : 32'd0;   // 1.0 at the center
      kernel_tab[1][i] = 32'd2621;                             // about 1/25 each
      kernel_tab[2][i] = (i == CENTER) ? 32'd98304 : -32'sd3277;  // 1.5 minus a ring
      kernel_tab[3][i] = $random(seed);                        // upper bits are junk
    end
  endtask

  task automatic apply_reset();
    rst    = 1'b1;
    pix_in = '0;
    repeat (10) @(negedge clk);
    rst = 1'b0;
  endtask

  // output and bus flags right after reset, bus idle, pixels zero
  task automatic check_idle();
    repeat (4) begin
      @(negedge clk);
      if (pix_out !== '0) begin
        pix_errs++;
        $display("Fail pix_out after reset: expected %h, got %h", 8'h00, pix_out);
      end
      if (apb_rsp.pready !== 1'b0 || apb_rsp.pslverr !== 1'b0) begin
        rd_errs++;
        $display("pready or pslverr is high while the bus is idle");
      end
    end
  endtask

  task automatic load_kernel(input int ki);
    logic [APB_AW-1:0] addr;
    for (int i = 0; i < NUM_TAPS; i++) begin
      addr = 4 * i;
      bfm0.write_word(addr, kernel_tab[ki][i], 1'b0);
      exp_coeff[i] = sign_extend_coeff(kernel_tab[ki][i]);
    end
  endtask

  task automatic check_bank();
    logic [APB_AW-1:0] addr;
    logic [APB_DW-1:0] data;
    for (int i = 0; i < NUM_TAPS; i++) begin
      addr = 4 * i;
      bfm0.read_word(addr, data, 1'b0);
      if (data !== exp_coeff[i]) begin
        rd_errs++;
        $display("Fail prdata word %0d: expected %h, got %h", i, exp_coeff[i], data);
      end
    end
  endtask

  // word 25 and the top word have no register behind them
  task automatic check_bad_address();
    logic [APB_DW-1:0] data;
    bfm0.write_word(8'd100, 32'h0001_2345, 1'b1);
    bfm0.read_word(8'd100, data, 1'b1);
    if (data !== '0) begin
      rd_errs++;
      $display("Fail prdata word 25: expected %h, got %h", 32'h0, data);
    end
    bfm0.read_word(8'hfc, data, 1'b1);
    if (data !== '0) begin
      rd_errs++;
      $display("Fail prdata word 63: expected %h, got %h", 32'h0, data);
    end
    check_bank();                       // the stray write changed nothing
  endtask

  task automatic stream_kernel(input int ki);
    pixel_t [KSIZE-1:0] col;
    pixel_t             exp_pix;
    for (int a = 0; a < HIST_LEN; a++) begin
      col_hist[a] = '0;                 // pipeline holds zeros by now
    end
    for (int j = 0; j <= STREAM_LEN + FLUSH_LEN; j++) begin
      @(negedge clk);                   // output of the edge that took col_hist[0]
      if (ki == IDENTITY_ENTRY) begin
        exp_pix = col_hist[HIST_LEN - 1 - KSIZE / 2][KSIZE / 2];  // row 2, 24 back
        if (pix_out !== exp_pix) begin
          pix_errs++;
          $display("Fail pix_out identity cycle %0d: expected %h, got %h", j, exp_pix, pix_out);
        end
      end
      if (j >= SETTLE) begin
        exp_pix = ref_pixel();
        if (pix_out !== exp_pix) begin
          pix_errs++;
          $display("Fail pix_out entry %0d cycle %0d: expected %h, got %h",
                   ki, j, exp_pix, pix_out);
        end
      end
      if (j < STREAM_LEN + FLUSH_LEN) begin
        for (int r = 0; r < KSIZE; r++) begin
          col[r] = (j < STREAM_LEN) ? pixel_t'($random(seed)) : '0;
        end
        pix_in = col;
        for (int a = HIST_LEN - 1; a > 0; a--) begin
          col_hist[a] = col_hist[a-1];  // age the window by one column
        end
        col_hist[0] = col;
      end
    end
  endtask

  initial begin
    build_table();
    apply_reset();
    check_idle();
    for (int i = 0; i < NUM_TAPS; i++) begin
      exp_coeff[i] = '0;                // bank clears on reset
    end
    check_bank();
    for (int e = 0; e < NUM_ENTRIES; e++) begin
      $display("kernel entry %0d", e);
      load_kernel(e);
      check_bank();
      if (e == IDENTITY_ENTRY) begin
        check_bad_address();
      end
      stream_kernel(e);
    end
    $display("errors: pixel %0d, readback %0d, bus %0d", pix_errs, rd_errs, bfm0.err_count);
    if (pix_errs + rd_errs + bfm0.err_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("run did not finish within %0d ns", WATCHDOG_NS);
    $display("errors: pixel %0d, readback %0d, bus %0d", pix_errs, rd_errs, bfm0.err_count);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

/* verilog.f */
source/conv_pkg.sv
source/coeff_regs.sv
source/row_skew.sv
source/mac_tap.sv
source/conv5x5_top.sv
tests/apb_master_bfm.sv
tests/conv5x5_tb.sv
